/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;
    localparam int ticket_width   = 4;
    localparam int offset_width   = 25;

    // Instruction field positions
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 25;
    localparam int rd_msb     = 24;
    localparam int rd_lsb     = 20;
    localparam int ra_msb     = 19;
    localparam int ra_lsb     = 15;
    localparam int rb_msb     = 14;
    localparam int rb_lsb     = 10;
    localparam int imm_msb    = 14;
    localparam int imm_lsb    = 0;
    // Low part of the branch offset, the high part sits in the rd field
    localparam int beq_lo_msb = 9;
    localparam int jump_msb   = 24;

    typedef logic [data_width-1:0]     data_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [ticket_width-1:0]   ticket_t;

    typedef enum logic [opcode_msb-opcode_lsb:0]
    {
        op_add   = 7'd0,
        op_sub   = 7'd1,
        op_and   = 7'd2,
        op_or    = 7'd3,
        op_mul   = 7'd4,
        op_addi  = 7'd5,
        op_load  = 7'd6,
        op_store = 7'd7,
        op_beq   = 7'd8,
        op_jump  = 7'd9,
        op_nop   = 7'd10
    } opcode_e;

    ////////////////////////////////////////
    // Instruction classes

    function automatic logic is_r_type(input opcode_e op);
        return (op == op_add) || (op == op_sub) || (op == op_and) || (op == op_or);
    endfunction

    function automatic logic is_mul(input opcode_e op);
        return op == op_mul;
    endfunction

    function automatic logic is_addi(input opcode_e op);
        return op == op_addi;
    endfunction

    function automatic logic is_load(input opcode_e op);
        return op == op_load;
    endfunction

    function automatic logic is_store(input opcode_e op);
        return op == op_store;
    endfunction

    function automatic logic is_branch(input opcode_e op);
        return op == op_beq;
    endfunction

    function automatic logic is_jump(input opcode_e op);
        return op == op_jump;
    endfunction

    function automatic logic is_nop(input opcode_e op);
        return op == op_nop;
    endfunction

    // Any encoding outside the enum members is illegal
    function automatic logic is_legal(input opcode_e op);
        return is_r_type(op) || is_mul(op) || is_addi(op) || is_load(op)
            || is_store(op) || is_branch(op) || is_jump(op) || is_nop(op);
    endfunction

endpackage

`default_nettype wire

/* hdl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    import isa_pkg::*;

    // Result coming back from the later stages
    typedef struct packed
    {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
        ticket_t   ticket;
    } wb_req_t;

    // Dependency state of one source operand
    typedef struct packed
    {
        logic    blocked;
        ticket_t ticket;
    } src_status_t;

    typedef struct packed
    {
        opcode_e                 opcode;
        reg_addr_t               rd;
        reg_addr_t               ra;
        reg_addr_t               rb;
        logic [offset_width-1:0] offset;
        logic                    uses_src1;
        logic                    uses_src2_rb;
        // Store reads rd as its second source
        logic                    uses_src2_rd;
        logic                    writes_rd;
        logic                    is_mul;
        logic                    illegal;
    } decoded_t;

    typedef struct packed
    {
        opcode_e                 opcode;
        reg_addr_t               rd;
        reg_addr_t               ra;
        reg_addr_t               rb;
        data_t                   ra_data;
        data_t                   rb_data;
        logic [offset_width-1:0] offset;
        ticket_t                 ticket;
        src_status_t             src1;
        src_status_t             src2;
        logic                    illegal;
    } alu_req_t;

    typedef struct packed
    {
        reg_addr_t   rd;
        reg_addr_t   ra;
        reg_addr_t   rb;
        data_t       ra_data;
        data_t       rb_data;
        ticket_t     ticket;
        src_status_t src1;
        src_status_t src2;
    } mul_req_t;

endpackage

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
(
    input  isa_pkg::data_t      instr,
    output decode_pkg::decoded_t dec
);

    import isa_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[opcode_msb:opcode_lsb]);

    ////////////////////////////////////////
    // Register fields

    always_comb
    begin
        dec.opcode = opcode;
        dec.rd     = instr[rd_msb:rd_lsb];
        dec.ra     = instr[ra_msb:ra_lsb];
        dec.rb     = instr[rb_msb:rb_lsb];
    end

    ////////////////////////////////////////
    // Immediate

    always_comb
    begin
        // Default is the low immediate, used by addi, load and store
        dec.offset = offset_width'(instr[imm_msb:imm_lsb]);

        if (is_branch(opcode))
        begin
            // Rd field on top of the ten low bits
            dec.offset = offset_width'({instr[rd_msb:rd_lsb], instr[beq_lo_msb:0]});
        end
        else if (is_jump(opcode))
        begin
            dec.offset = offset_width'(instr[jump_msb:0]);
        end
    end

    ////////////////////////////////////////
    // Operand usage and class flags

    always_comb
    begin
        dec.uses_src1    = is_r_type(opcode) | is_mul(opcode) | is_load(opcode)
                         | is_store(opcode) | is_branch(opcode);

        dec.uses_src2_rb = is_r_type(opcode) | is_mul(opcode) | is_branch(opcode);
        dec.uses_src2_rd = is_store(opcode);

        // Producers that claim rd in the scoreboard
        dec.writes_rd    = is_r_type(opcode) | is_mul(opcode) | is_addi(opcode)
                         | is_load(opcode);

        dec.is_mul       = is_mul(opcode);
        // Unknown encodings still go to the ALU, with this flag set
        dec.illegal      = !is_legal(opcode);
    end

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    accept,
    input  decode_pkg::decoded_t    dec,
    input  decode_pkg::wb_req_t     wb,
    output decode_pkg::src_status_t src1,
    output decode_pkg::src_status_t src2,
    output isa_pkg::ticket_t        ticket
);

    import isa_pkg::*;
    import decode_pkg::*;

    // One pending flag and one owner ticket per register
    logic [num_regs-1:0]          blocked;
    ticket_t [num_regs-1:0]       tickets;
    ticket_t                      counter;

    reg_addr_t                    src2_addr;
    logic                         src2_used;

    ////////////////////////////////////////
    // Source lookup

    // A write-back in the same cycle with the owner ticket releases the source
    function automatic src_status_t status_of
    (
        input logic    used,
        input logic    blk,
        input ticket_t owner,
        input wb_req_t w
    );
        src_status_t s;
        s.blocked = used & blk & !(w.valid && (w.ticket == owner));
        s.ticket  = used ? owner : '0;
        return s;
    endfunction

    assign src2_addr = dec.uses_src2_rd ? dec.rd : dec.rb;
    assign src2_used = dec.uses_src2_rb | dec.uses_src2_rd;

    assign src1   = status_of(dec.uses_src1, blocked[dec.ra], tickets[dec.ra], wb);
    assign src2   = status_of(src2_used, blocked[src2_addr], tickets[src2_addr], wb);

    // Every accepted instruction takes the current count
    assign ticket = counter;

    ////////////////////////////////////////
    // Update

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            blocked <= '0;
            tickets <= '0;
            counter <= '0;
        end
        else if (flush)
        begin
            // Nothing in flight survives a flush
            blocked <= '0;
            counter <= '0;
        end
        else
        begin
            if (wb.valid && (tickets[wb.addr] == wb.ticket))
            begin
                blocked[wb.addr] <= 1'b0;
            end

            // Claim comes last so a new producer wins over a release on the same rd
            if (accept)
            begin
                counter <= counter + 1'b1;
                if (dec.writes_rd)
                begin
                    blocked[dec.rd] <= 1'b1;
                    tickets[dec.rd] <= counter;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
(
    input  logic                clock,
    input  logic                arst_n,

    // Read ports
    input  isa_pkg::reg_addr_t  rd_addr_a,
    input  isa_pkg::reg_addr_t  rd_addr_b,
    output isa_pkg::data_t      rd_data_a,
    output isa_pkg::data_t      rd_data_b,

    // Write port from write-back
    input  decode_pkg::wb_req_t wb
);

    import isa_pkg::*;

    data_t [num_regs-1:0] regs;

    logic                 hit_a;
    logic                 hit_b;

    ////////////////////////////////////////
    // Write

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            regs <= '0;
        end
        else if (wb.valid)
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    ////////////////////////////////////////
    // Read with write-back bypass

    assign hit_a = wb.valid && (wb.addr == rd_addr_a);
    assign hit_b = wb.valid && (wb.addr == rd_addr_b);

    // Value being written this cycle is newer than the stored one
    assign rd_data_a = hit_a ? wb.data : regs[rd_addr_a];
    assign rd_data_b = hit_b ? wb.data : regs[rd_addr_b];

endmodule

`default_nettype wire

/* hdl/issue_register.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_register
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    accept,
    input  logic                    flush,

    // Decoded instruction and its operands
    input  decode_pkg::decoded_t    dec,
    input  isa_pkg::data_t          ra_data,
    input  isa_pkg::data_t          rb_data,
    input  decode_pkg::src_status_t src1,
    input  decode_pkg::src_status_t src2,
    input  isa_pkg::ticket_t        ticket,

    // Requests to the execution units
    output logic                    alu_req_valid,
    output decode_pkg::alu_req_t    alu_req,
    output logic                    mul_req_valid,
    output decode_pkg::mul_req_t    mul_req
);

    import decode_pkg::*;

    alu_req_t alu_next;
    mul_req_t mul_next;
    logic     alu_valid_q;
    logic     mul_valid_q;

    ////////////////////////////////////////
    // Request assembly

    always_comb
    begin
        alu_next.opcode  = dec.opcode;
        alu_next.rd      = dec.rd;
        alu_next.ra      = dec.ra;
        alu_next.rb      = dec.rb;
        alu_next.ra_data = ra_data;
        alu_next.rb_data = rb_data;
        alu_next.offset  = dec.offset;
        alu_next.ticket  = ticket;
        alu_next.src1    = src1;
        alu_next.src2    = src2;
        alu_next.illegal = dec.illegal;

        mul_next.rd      = dec.rd;
        mul_next.ra      = dec.ra;
        mul_next.rb      = dec.rb;
        mul_next.ra_data = ra_data;
        mul_next.rb_data = rb_data;
        mul_next.ticket  = ticket;
        mul_next.src1    = src1;
        mul_next.src2    = src2;
    end

    ////////////////////////////////////////
    // Valids

    // Reloaded every cycle, so a stalled or flushed cycle issues nothing
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= 1'b0;
        end
        else
        begin
            alu_valid_q <= accept & !dec.is_mul;
            mul_valid_q <= accept & dec.is_mul;
        end
    end

    // Payload only moves when an instruction is taken
    always_ff @(posedge clock)
    begin
        if (accept && !dec.is_mul)
        begin
            alu_req <= alu_next;
        end
        if (accept && dec.is_mul)
        begin
            mul_req <= mul_next;
        end
    end

    // Flush kills the request in flight in the same cycle
    assign alu_req_valid = alu_valid_q & !flush;
    assign mul_req_valid = mul_valid_q & !flush;

endmodule

`default_nettype wire

/* hdl/decode_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top
(
    input  logic                 clock,
    input  logic                 arst_n,

    // Fetch side
    input  logic                 instr_valid,
    input  isa_pkg::data_t       instr,

    // Control from later stages
    input  logic                 stall,
    input  logic                 flush,
    input  decode_pkg::wb_req_t  wb,

    // Issue side
    output logic                 alu_req_valid,
    output decode_pkg::alu_req_t alu_req,
    output logic                 mul_req_valid,
    output decode_pkg::mul_req_t mul_req
);

    import isa_pkg::*;
    import decode_pkg::*;

    logic        accept;
    decoded_t    dec;
    reg_addr_t   rd_addr_b;
    data_t       ra_data;
    data_t       rb_data;
    src_status_t src1;
    src_status_t src2;
    ticket_t     ticket;

    // Fetch holds the instruction while stall is high
    assign accept    = instr_valid & !stall & !flush;

    // Store data comes from rd
    assign rd_addr_b = dec.uses_src2_rd ? dec.rd : dec.rb;

    ////////////////////////////////////////
    // Datapath

    instr_decoder instr_decoder_inst
    (
        .instr     (instr),
        .dec       (dec)
    );

    register_file register_file_inst
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .rd_addr_a (dec.ra),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (ra_data),
        .rd_data_b (rb_data),
        .wb        (wb)
    );

    scoreboard scoreboard_inst
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .flush     (flush),
        .accept    (accept),
        .dec       (dec),
        .wb        (wb),
        .src1      (src1),
        .src2      (src2),
        .ticket    (ticket)
    );

    issue_register issue_register_inst
    (
        .clock         (clock),
        .arst_n        (arst_n),
        .accept        (accept),
        .flush         (flush),
        .dec           (dec),
        .ra_data       (ra_data),
        .rb_data       (rb_data),
        .src1          (src1),
        .src2          (src2),
        .ticket        (ticket),
        .alu_req_valid (alu_req_valid),
        .alu_req       (alu_req),
        .mul_req_valid (mul_req_valid),
        .mul_req       (mul_req)
    );

endmodule

`default_nettype wire

/* dv/decode_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_asserts
(
    input logic clock,
    input logic arst_n,
    input logic accept,
    input logic flush,
    input logic alu_req_valid,
    input logic mul_req_valid
);

    // Polled by the testbench every cycle
    int fail_count = 0;

    ////////////////////////////////////////
    // Request protocol

    // Only one execution unit gets a request per cycle
    valid_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(alu_req_valid && mul_req_valid))
    else
    begin
        fail_count++;
        $error("ALU and MUL requests raised in the same cycle");
    end

    // Flush masks both requests in its own cycle
    flush_masks_valid: assert property (@(posedge clock) disable iff (!arst_n)
        flush |-> !alu_req_valid && !mul_req_valid)
    else
    begin
        fail_count++;
        $error("Request valid while flush is high");
    end

    // A stalled cycle accepts nothing, so the next cycle issues nothing
    stall_gap: assert property (@(posedge clock) disable iff (!arst_n)
        !accept |=> !alu_req_valid && !mul_req_valid)
    else
    begin
        fail_count++;
        $error("Request valid after a cycle without accept");
    end

endmodule

bind issue_register decode_stage_asserts issue_asserts_inst
(
    .clock         (clock),
    .arst_n        (arst_n),
    .accept        (accept),
    .flush         (flush),
    .alu_req_valid (alu_req_valid),
    .mul_req_valid (mul_req_valid)
);

`default_nettype wire

/* dv/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    import isa_pkg::*;
    import decode_pkg::*;

    localparam int clock_period  = 100;
    // Reset, then bypass, steering, dependency, tickets, stall/flush, illegal
    localparam int test_cycles   = 2 + 14 + 12 + 7 + 19 + 7 + 5;
    localparam int margin_cycles = 20;

    logic     clock = 1'b0;
    logic     arst_n;
    logic     instr_valid;
    data_t    instr;
    logic     stall;
    logic     flush;
    wb_req_t  wb;
    logic     alu_req_valid;
    alu_req_t alu_req;
    logic     mul_req_valid;
    mul_req_t mul_req;

    // Reference model state
    data_t    m_regs [num_regs];
    logic     m_blocked [num_regs];
    ticket_t  m_tickets [num_regs];
    ticket_t  m_counter;

    // Request expected in the cycle after the current one
    logic     exp_alu_valid;
    logic     exp_mul_valid;
    alu_req_t exp_alu;
    mul_req_t exp_mul;

    logic [31:0] lcg_state = 32'h2b00;

    always #(clock_period / 2) clock = ~clock;

    decode_stage_top decode_stage_top_inst
    (
        .clock         (clock),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .stall         (stall),
        .flush         (flush),
        .wb            (wb),
        .alu_req_valid (alu_req_valid),
        .alu_req       (alu_req),
        .mul_req_valid (mul_req_valid),
        .mul_req       (mul_req)
    );

    ////////////////////////////////////////
    // Failure reporting and compares

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_alu(input alu_req_t got, input alu_req_t exp);
        if (got !== exp)
        begin
            $display("error alu_req: got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_mul(input mul_req_t got, input mul_req_t exp);
        if (got !== exp)
        begin
            $display("error mul_req: got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers

    function automatic data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t encode(input logic [6:0] op, input reg_addr_t rd,
                                     input reg_addr_t ra, input logic [14:0] low);
        return {op, rd, ra, low};
    endfunction

    function automatic data_t r_type(input logic [6:0] op, input reg_addr_t rd,
                                     input reg_addr_t ra, input reg_addr_t rb);
        return {op, rd, ra, rb, 10'h0};
    endfunction

    function automatic wb_req_t make_wb(input reg_addr_t addr, input data_t data,
                                        input ticket_t tkt);
        wb_req_t w;
        w.valid  = 1'b1;
        w.addr   = addr;
        w.data   = data;
        w.ticket = tkt;
        return w;
    endfunction

    ////////////////////////////////////////
    // Reference model

    function automatic data_t read_value(input reg_addr_t a, input wb_req_t w);
        return (w.valid && (w.addr == a)) ? w.data : m_regs[a];
    endfunction

    function automatic src_status_t source_status(input logic used, input reg_addr_t a,
                                                  input wb_req_t w);
        src_status_t s;
        s.blocked = used && m_blocked[a] && !(w.valid && (w.ticket == m_tickets[a]));
        s.ticket  = used ? m_tickets[a] : '0;
        return s;
    endfunction

    function automatic logic [offset_width-1:0] expected_offset(input data_t ins);
        case (ins[31:25])
            op_beq:  return {10'h0, ins[24:20], ins[9:0]};
            op_jump: return ins[24:0];
            default: return {10'h0, ins[14:0]};
        endcase
    endfunction

    task automatic predict(input logic acc, input data_t ins, input wb_req_t w);
        logic [6:0]  op;
        reg_addr_t   b_addr;
        logic        use1;
        logic        use2;
        src_status_t s1;
        src_status_t s2;
        op     = ins[31:25];
        b_addr = (op == op_store) ? ins[24:20] : ins[14:10];
        use1   = op inside {op_add, op_sub, op_and, op_or, op_mul, op_load, op_store, op_beq};
        use2   = op inside {op_add, op_sub, op_and, op_or, op_mul, op_store, op_beq};
        s1     = source_status(use1, ins[19:15], w);
        s2     = source_status(use2, b_addr, w);
        exp_alu_valid = acc && (op != op_mul);
        exp_mul_valid = acc && (op == op_mul);
        if (exp_alu_valid)
        begin
            exp_alu.opcode  = opcode_e'(op);
            exp_alu.rd      = ins[24:20];
            exp_alu.ra      = ins[19:15];
            exp_alu.rb      = ins[14:10];
            exp_alu.ra_data = read_value(ins[19:15], w);
            exp_alu.rb_data = read_value(b_addr, w);
            exp_alu.offset  = expected_offset(ins);
            exp_alu.ticket  = m_counter;
            exp_alu.src1    = s1;
            exp_alu.src2    = s2;
            exp_alu.illegal = op > 7'd10;
        end
        if (exp_mul_valid)
        begin
            exp_mul.rd      = ins[24:20];
            exp_mul.ra      = ins[19:15];
            exp_mul.rb      = ins[14:10];
            exp_mul.ra_data = read_value(ins[19:15], w);
            exp_mul.rb_data = read_value(ins[14:10], w);
            exp_mul.ticket  = m_counter;
            exp_mul.src1    = s1;
            exp_mul.src2    = s2;
        end
    endtask

    // State change at the clock edge
    task automatic update_model(input logic acc, input data_t ins, input logic fl,
                                input wb_req_t w);
        logic [6:0] op;
        op = ins[31:25];
        if (w.valid)
        begin
            m_regs[w.addr] = w.data;
        end
        if (fl)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                m_blocked[i] = 1'b0;
            end
            m_counter = '0;
        end
        else
        begin
            if (w.valid && (m_tickets[w.addr] == w.ticket))
            begin
                m_blocked[w.addr] = 1'b0;
            end
            if (acc)
            begin
                if (op inside {op_add, op_sub, op_and, op_or, op_mul, op_addi, op_load})
                begin
                    m_blocked[ins[24:20]] = 1'b1;
                    m_tickets[ins[24:20]] = m_counter;
                end
                m_counter = m_counter + 4'd1;
            end
        end
    endtask

    ////////////////////////////////////////
    // Cycle driver

    task automatic check_outputs(input logic fl);
        check_valid("alu_req_valid", alu_req_valid, exp_alu_valid && !fl);
        check_valid("mul_req_valid", mul_req_valid, exp_mul_valid && !fl);
        if (exp_alu_valid && !fl)
        begin
            compare_alu(alu_req, exp_alu);
        end
        if (exp_mul_valid && !fl)
        begin
            compare_mul(mul_req, exp_mul);
        end
        if (decode_stage_top_inst.issue_register_inst.issue_asserts_inst.fail_count != 0)
        begin
            $display("A bound protocol assertion on the request outputs failed");
            stop_with_failure();
        end
    endtask

    // Entered just after a rising edge, returns just after the next one
    task automatic run_cycle(input logic v, input data_t ins, input logic st, input logic fl,
                             input wb_req_t w);
        instr_valid = v;
        instr       = ins;
        stall       = st;
        flush       = fl;
        wb          = w;
        @(negedge clock);
        check_outputs(fl);
        predict(v && !st && !fl, ins, w);
        update_model(v && !st && !fl, ins, fl, w);
        @(posedge clock);
        #1;
    endtask

    task automatic issue(input data_t ins);
        run_cycle(1'b1, ins, 1'b0, 1'b0, '0);
    endtask

    task automatic idle();
        run_cycle(1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic write_back(input reg_addr_t addr, input data_t data, input ticket_t tkt);
        run_cycle(1'b0, '0, 1'b0, 1'b0, make_wb(addr, data, tkt));
    endtask

    ////////////////////////////////////////
    // Directed tests

    task automatic test_register_bypass();
        for (int i = 1; i <= 8; i++)
        begin
            write_back(reg_addr_t'(i), next_random(), 4'h0);
        end
        issue(r_type(op_add, 5'd10, 5'd1, 5'd2));
        issue(r_type(op_sub, 5'd11, 5'd3, 5'd4));
        issue(encode(op_addi, 5'd12, 5'd5, 15'h1234));
        // Write-back in the decode cycle must be bypassed
        run_cycle(1'b1, r_type(op_add, 5'd13, 5'd6, 5'd9), 1'b0, 1'b0,
                  make_wb(5'd9, next_random(), 4'h0));
        run_cycle(1'b1, r_type(op_or, 5'd14, 5'd7, 5'd7), 1'b0, 1'b0,
                  make_wb(5'd7, next_random(), 4'h0));
        idle();
    endtask

    task automatic test_steering();
        opcode_e alu_ops [10] = '{op_add, op_sub, op_and, op_or, op_addi,
                                  op_load, op_store, op_beq, op_jump, op_nop};
        data_t   r;
        issue(r_type(op_mul, 5'd15, 5'd1, 5'd2));
        for (int i = 0; i < 10; i++)
        begin
            r = next_random();
            issue({alu_ops[i], r[24:0]});
        end
        idle();
    endtask

    task automatic test_dependency();
        ticket_t owner;
        data_t   value;
        owner = m_counter;
        value = next_random();
        issue(r_type(op_add, 5'd20, 5'd1, 5'd2));
        issue(r_type(op_sub, 5'd21, 5'd20, 5'd3));
        // Wrong ticket keeps r20 blocked
        write_back(5'd20, value, owner + 4'd1);
        issue(r_type(op_sub, 5'd21, 5'd20, 5'd3));
        run_cycle(1'b1, r_type(op_or, 5'd22, 5'd20, 5'd3), 1'b0, 1'b0,
                  make_wb(5'd20, value, owner));
        // Store reads r22 as source 2
        issue(encode(op_store, 5'd22, 5'd1, 15'h0040));
        idle();
    endtask

    task automatic test_tickets();
        data_t r;
        for (int i = 0; i < 18; i++)
        begin
            r = next_random();
            issue({op_nop, r[24:0]});
        end
        idle();
    endtask

    task automatic test_stall_flush();
        data_t held;
        held = r_type(op_add, 5'd7, 5'd1, 5'd2);
        run_cycle(1'b1, held, 1'b1, 1'b0, '0);
        run_cycle(1'b1, held, 1'b1, 1'b0, '0);
        issue(held);
        issue(r_type(op_mul, 5'd8, 5'd7, 5'd3));
        // Mul request in flight is masked, new instruction is dropped
        run_cycle(1'b1, r_type(op_sub, 5'd9, 5'd8, 5'd7), 1'b0, 1'b1, '0);
        issue(r_type(op_and, 5'd9, 5'd7, 5'd8));
        idle();
    endtask

    task automatic test_illegal();
        run_cycle(1'b0, '0, 1'b0, 1'b1, '0);
        issue(r_type(7'h0b, 5'd9, 5'd1, 5'd2));
        issue(r_type(7'h7f, 5'd10, 5'd9, 5'd9));
        issue(r_type(op_add, 5'd11, 5'd9, 5'd10));
        idle();
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog

    initial
    begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb          = '0;
        for (int i = 0; i < num_regs; i++)
        begin
            m_regs[i]    = '0;
            m_blocked[i] = 1'b0;
            m_tickets[i] = '0;
        end
        m_counter     = '0;
        exp_alu_valid = 1'b0;
        exp_mul_valid = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        arst_n = 1'b1;
        test_register_bypass();
        test_steering();
        test_dependency();
        test_tickets();
        test_stall_flush();
        test_illegal();
        if (decode_stage_top_inst.issue_register_inst.issue_asserts_inst.fail_count == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            stop_with_failure();
        end
    end

    initial
    begin
        #((test_cycles + margin_cycles) * clock_period);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* decode_stage_top.f */
hdl/isa_pkg.sv
hdl/decode_pkg.sv
hdl/instr_decoder.sv
hdl/scoreboard.sv
hdl/register_file.sv
hdl/issue_register.sv
hdl/decode_stage_top.sv
dv/decode_stage_asserts.sv
dv/decode_stage_tb.sv
